// File: core_top.sv
////////////////////////////////////////////////////////////
// test pattern core top level
// raster timing, grey fill video, status registers on
// wishbone and a silent i2s stream
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_top #(
    parameter int BLINK_BIT = 24
) (
    input  logic                              clk_core_12288,
    input  logic                              reset_n,

    // register bus
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [pattern_pkg::BUS_ADDR_W-1:0] wb_adr,
    input  logic [pattern_pkg::BUS_DATA_W-1:0] wb_dat_w,
    output logic [pattern_pkg::BUS_DATA_W-1:0] wb_dat_r,
    output logic                              wb_ack,

    // video to scaler
    output logic [pattern_pkg::PIXEL_W-1:0]    video_rgb,
    output logic                              video_de,
    output logic                              video_vs,
    output logic                              video_hs,

    // audio
    output logic                              audio_mclk,
    output logic                              audio_sclk,
    output logic                              audio_lrck,
    output logic                              audio_dac
);

    ////////////////////////////////////////////////////////////
    // raster

    logic [pattern_pkg::COORD_W-1:0] x_count;
    logic [pattern_pkg::COORD_W-1:0] y_count;
    logic                           frame_start;

    video_timing u_video_timing (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .x_count        (x_count),
        .y_count        (y_count),
        .frame_start    (frame_start)
    );

    // one clock from raster position to pins
    video_output u_video_output (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .x_count        (x_count),
        .y_count        (y_count),
        .frame_start    (frame_start),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs)
    );

    ////////////////////////////////////////////////////////////
    // status and registers

    logic [pattern_pkg::FRAME_W-1:0] frame_count;
    logic                           blink_flag;

    status_counters #(
        .BLINK_BIT (BLINK_BIT)
    ) u_status_counters (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .frame_start    (frame_start),
        .frame_count    (frame_count),
        .blink_flag     (blink_flag)
    );

    reg_bus u_reg_bus (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .frame_count    (frame_count),
        .blink_flag     (blink_flag)
    );

    ////////////////////////////////////////////////////////////
    // audio

    // mclk is the core clock itself
    assign audio_mclk = clk_core_12288;

    i2s_silence u_i2s_silence (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .i2s_sclk       (audio_sclk),
        .i2s_lrck       (audio_lrck),
        .i2s_dac        (audio_dac)
    );

endmodule

// File: i2s_silence.sv
////////////////////////////////////////////////////////////
// silent i2s transmitter
// bit clock at core clock / 4, 32 bits per word select half
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module i2s_silence (
    input  logic clk_core_12288,
    input  logic reset_n,
    output logic i2s_sclk,
    output logic i2s_lrck,
    output logic i2s_dac
);

    logic [1:0] sclk_div;
    logic [4:0] bit_count;
    // sclk drops on the next edge
    logic       sclk_fall;

    // bit clock divider
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div <= '0;
        end else begin
            sclk_div <= sclk_div + 1'b1;
        end
    end

    assign i2s_sclk = sclk_div[1];

    // top bit goes 1 -> 0 when the divider rolls over
    assign sclk_fall = (sclk_div == 2'b11);

    // word select, one channel per 32 bit clocks
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            bit_count <= '0;
            i2s_lrck  <= 1'b0;
        end else if (sclk_fall) begin
            bit_count <= bit_count + 1'b1;
            // switch channels
            if (bit_count == 5'd31) begin
                i2s_lrck <= ~i2s_lrck;
            end
        end
    end

    // no samples, data line parked low
    assign i2s_dac = 1'b0;

endmodule

// File: pattern_pkg.sv
////////////////////////////////////////////////////////////
// pattern core shared definitions
// raster geometry, colour level, bus widths and encodings
////////////////////////////////////////////////////////////

package pattern_pkg;

    ////////////////////////////////////////////////////////////
    // raster geometry

    // x and y counts fit 512 lines
    parameter int COORD_W = 10;

    // 400 clocks per line, 320 visible after a 10 clock porch
    parameter int H_TOTAL  = 400;
    parameter int H_BPORCH = 10;
    parameter int H_ACTIVE = 320;

    // 512 lines per frame, 240 visible after a 10 line porch
    parameter int V_TOTAL  = 512;
    parameter int V_BPORCH = 10;
    parameter int V_ACTIVE = 240;

    // hs lands a few clocks after vs, never on the same cycle
    parameter int HS_X = 3;

    ////////////////////////////////////////////////////////////
    // pixel data

    parameter int PIXEL_W = 24;
    // per channel grey of the active area
    parameter logic [7:0] FILL_LEVEL = 8'd60;

    // frame counter width
    parameter int FRAME_W = 16;

    ////////////////////////////////////////////////////////////
    // register bus

    parameter int BUS_ADDR_W = 32;
    parameter int BUS_DATA_W = 32;

    // readable status registers
    typedef enum logic [BUS_ADDR_W-1:0] {
        REG_BLINK       = 32'h0010_0000,
        REG_FRAME_COUNT = 32'h0010_0004
    } reg_addr_e;

    // slave handshake states
    typedef enum logic {
        bus_idle = 1'b0,
        bus_ack  = 1'b1
    } bus_state_e;

endpackage

// File: reg_bus.sv
////////////////////////////////////////////////////////////
// wishbone classic register slave
// single cycle ack, read mux over the status registers
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module reg_bus (
    input  logic                              clk_core_12288,
    input  logic                              reset_n,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [pattern_pkg::BUS_ADDR_W-1:0] wb_adr,
    input  logic [pattern_pkg::BUS_DATA_W-1:0] wb_dat_w,
    output logic [pattern_pkg::BUS_DATA_W-1:0] wb_dat_r,
    output logic                              wb_ack,
    input  logic [pattern_pkg::FRAME_W-1:0]    frame_count,
    input  logic                              blink_flag
);

    pattern_pkg::bus_state_e state;

    logic                              req;
    logic [pattern_pkg::BUS_DATA_W-1:0] rd_mux;

    assign req = wb_cyc && wb_stb;

    ////////////////////////////////////////////////////////////
    // read mux

    // unmapped addresses read back as zero
    always_comb begin
        case (wb_adr)
            pattern_pkg::REG_BLINK: begin
                rd_mux = {{(pattern_pkg::BUS_DATA_W-1){1'b0}}, blink_flag};
            end
            pattern_pkg::REG_FRAME_COUNT: begin
                rd_mux = {{(pattern_pkg::BUS_DATA_W-pattern_pkg::FRAME_W){1'b0}},
                          frame_count};
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // handshake FSM

    // idle -> ack on a request, ack -> idle unconditionally
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            state <= pattern_pkg::bus_idle;
        end else begin
            case (state)
                pattern_pkg::bus_idle: if (req) state <= pattern_pkg::bus_ack;
                default:               state <= pattern_pkg::bus_idle;
            endcase
        end
    end

    assign wb_ack = (state == pattern_pkg::bus_ack);

    // read data captured on the edge that raises ack
    // write data goes nowhere, writes read back zero
    always_ff @(posedge clk_core_12288) begin
        if (state == pattern_pkg::bus_idle && req) begin
            wb_dat_r <= wb_we ? '0 : rd_mux;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the core_top testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_core_top \
    -f vlog.f -o tb_core_top_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_core_top_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1

// File: status_counters.sv
////////////////////////////////////////////////////////////
// status counters
// frame count and free running blink flag
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module status_counters #(
    parameter int BLINK_BIT = 24
) (
    input  logic                           clk_core_12288,
    input  logic                           reset_n,
    input  logic                           frame_start,
    output logic [pattern_pkg::FRAME_W-1:0] frame_count,
    output logic                           blink_flag
);

    // free running divider for the blink flag
    logic [31:0] blink_count;

    // counts on the edge that raises vs
    // so it equals the number of vs pulses so far
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            frame_count <= '0;
        end else if (frame_start) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // counter steps every clock
    // flag takes the chosen bit one clock later
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            blink_count <= '0;
            blink_flag  <= 1'b0;
        end else begin
            blink_count <= blink_count + 1'b1;
            blink_flag  <= blink_count[BLINK_BIT];
        end
    end

endmodule

// File: tb_core_top.sv
////////////////////////////////////////////////////////////
// core_top testbench
// raster, register bus, blink and audio checks against
// reference models of the pattern core
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_core_top;

    localparam int BLINK_BIT  = 6;
    localparam int FRAME_CLKS = pattern_pkg::H_TOTAL * pattern_pkg::V_TOTAL;
    localparam int CHECK_CLKS = 2 * FRAME_CLKS;
    localparam int ACK_LIMIT  = 16;
    localparam int X_END      = pattern_pkg::H_BPORCH + pattern_pkg::H_ACTIVE;
    localparam int Y_END      = pattern_pkg::V_BPORCH + pattern_pkg::V_ACTIVE;

    logic        clk_core_12288;
    logic        reset_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic        audio_mclk;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    // active edges since reset release
    int   cycle = 0;
    int   error_count = 0;
    int   timeout_count = 0;
    // monitor history
    logic ack_prev = 1'b0;
    logic sclk_prev = 1'b0;
    logic lrck_prev = 1'b0;
    int   sclk_rise_at = 0;
    int   sclk_rises = 0;
    int   lrck_rise_at = 0;
    int   lrck_rises = 0;

    core_top #(
        .BLINK_BIT (BLINK_BIT)
    ) u_core_top (
        .clk_core_12288 (clk_core_12288),
        .reset_n        (reset_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_vs       (video_vs),
        .video_hs       (video_hs),
        .audio_mclk     (audio_mclk),
        .audio_sclk     (audio_sclk),
        .audio_lrck     (audio_lrck),
        .audio_dac      (audio_dac)
    );

    // 8 ns period
    always #4 clk_core_12288 = ~clk_core_12288;

    always @(posedge clk_core_12288) begin
        if (reset_n) begin
            cycle <= cycle + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // reference models

    // {vs, hs, de, rgb} for a raster position counted from the top left
    function automatic logic [26:0] video_reference(input int pos);
        int   x;
        int   y;
        logic de;
        x  = pos % pattern_pkg::H_TOTAL;
        y  = (pos / pattern_pkg::H_TOTAL) % pattern_pkg::V_TOTAL;
        de = (x >= pattern_pkg::H_BPORCH) && (x < X_END) &&
             (y >= pattern_pkg::V_BPORCH) && (y < Y_END);
        return {(x == 0 && y == 0), (x == pattern_pkg::HS_X), de,
                de ? {3{pattern_pkg::FILL_LEVEL}} : 24'h0};
    endfunction

    // register contents after k active edges
    function automatic logic [31:0] register_reference(input logic [31:0] addr, input int k);
        logic [31:0] value;
        value = '0;
        if (addr == pattern_pkg::REG_FRAME_COUNT && k > 0) begin
            // one vs pulse per frame, the first at position 0
            value = 32'((k - 1) / FRAME_CLKS + 1);
        end else if (addr == pattern_pkg::REG_BLINK && k > 0) begin
            // flag lags the counter bit by a clock
            value = 32'(((k - 1) >> BLINK_BIT) & 1);
        end
        return value;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        error_count++;
    endtask

    ////////////////////////////////////////////////////////////
    // output monitor, sampled mid cycle

    always @(negedge clk_core_12288) begin
        logic [26:0] exp_video;
        if (!reset_n) begin
            if (video_de !== 1'b0) report_mismatch("video_de", video_de, 0);
            if (video_vs !== 1'b0) report_mismatch("video_vs", video_vs, 0);
            if (video_hs !== 1'b0) report_mismatch("video_hs", video_hs, 0);
            if (video_rgb !== 24'h0) report_mismatch("video_rgb", video_rgb, 0);
            if (wb_ack !== 1'b0) report_mismatch("wb_ack", wb_ack, 0);
        end else if (cycle >= 1 && cycle <= CHECK_CLKS) begin
            // pins show the position of the previous clock
            exp_video = video_reference(cycle - 1);
            if (video_vs !== exp_video[26]) report_mismatch("video_vs", video_vs, exp_video[26]);
            if (video_hs !== exp_video[25]) report_mismatch("video_hs", video_hs, exp_video[25]);
            if (video_de !== exp_video[24]) report_mismatch("video_de", video_de, exp_video[24]);
            if (video_rgb !== exp_video[23:0]) begin
                report_mismatch("video_rgb", video_rgb, exp_video[23:0]);
            end
        end
        if (reset_n && cycle >= 1) begin
            if (audio_dac !== 1'b0) report_mismatch("audio_dac", audio_dac, 0);
            // periods from rising edge to rising edge
            if (audio_sclk && !sclk_prev) begin
                if (sclk_rise_at > 0 && cycle - sclk_rise_at != 4) begin
                    report_mismatch("audio_sclk period", cycle - sclk_rise_at, 4);
                end
                sclk_rise_at = cycle;
                sclk_rises++;
            end
            if (audio_lrck && !lrck_prev) begin
                if (lrck_rise_at > 0 && cycle - lrck_rise_at != 256) begin
                    report_mismatch("audio_lrck period", cycle - lrck_rise_at, 256);
                end
                lrck_rise_at = cycle;
                lrck_rises++;
            end
        end
        if (wb_ack && ack_prev) begin
            $display("ERROR at %0t: wb_ack stayed high for two cycles", $time);
            error_count++;
        end
        sclk_prev = audio_sclk;
        lrck_prev = audio_lrck;
        ack_prev  = wb_ack;
    end

    // forwarded master clock follows the core clock level
    always @(clk_core_12288) begin
        #2;
        if (audio_mclk !== clk_core_12288) begin
            report_mismatch("audio_mclk", audio_mclk, clk_core_12288);
        end
    end

    ////////////////////////////////////////////////////////////
    // wishbone master

    // stb stays up from a previous access for back to back cycles
    task automatic bus_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int ack_cycle);
        int waited;
        waited = 0;
        @(posedge clk_core_12288);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        @(negedge clk_core_12288);
        while (wb_ack !== 1'b1 && waited < ACK_LIMIT) begin
            @(negedge clk_core_12288);
            waited++;
        end
        if (wb_ack !== 1'b1) begin
            $display("ERROR at %0t: no ack for access to address %h", $time, addr);
            timeout_count++;
        end
        rdata     = wb_dat_r;
        ack_cycle = cycle;
    endtask

    task automatic bus_release();
        @(posedge clk_core_12288);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // data is registered on the ack edge from the previous clock's state
    task automatic read_and_check(input logic [31:0] addr, output logic [31:0] rdata,
                                  output int ack_cycle);
        logic [31:0] expected;
        bus_access(1'b0, addr, 32'h0, rdata, ack_cycle);
        expected = register_reference(addr, ack_cycle - 1);
        if (rdata !== expected) report_mismatch("wb_dat_r", rdata, expected);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        logic [31:0] rdata;
        logic        blink_prev;
        int          ack_cycle;
        int          start;
        int          last_change;
        int          changes;
        int          frames_max;
        int          waited;
        clk_core_12288 = 1'b0;
        reset_n        = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        void'($urandom(38));
        repeat (2) @(posedge clk_core_12288);
        reset_n <= 1'b1;

        // unmapped addresses read zero
        read_and_check(32'h0010_0008, rdata, ack_cycle);
        read_and_check(32'h0000_0000, rdata, ack_cycle);
        bus_release();
        // write acked, count keeps running normally
        bus_access(1'b1, pattern_pkg::REG_FRAME_COUNT, 32'hffff_ffff, rdata, ack_cycle);
        bus_release();
        read_and_check(pattern_pkg::REG_FRAME_COUNT, rdata, ack_cycle);
        bus_release();

        // back to back blink reads, two clocks apart
        read_and_check(pattern_pkg::REG_BLINK, rdata, ack_cycle);
        start       = ack_cycle;
        blink_prev  = rdata[0];
        last_change = 0;
        changes     = 0;
        while (ack_cycle - start < 1000) begin
            read_and_check(pattern_pkg::REG_BLINK, rdata, ack_cycle);
            if (rdata[0] != blink_prev) begin
                if (last_change > 0 && ack_cycle - last_change != 64) begin
                    report_mismatch("blink change interval", ack_cycle - last_change, 64);
                end
                last_change = ack_cycle;
                changes++;
            end
            blink_prev = rdata[0];
        end
        bus_release();
        if (changes < 2) begin
            $display("ERROR: blink flag changed only %0d times", changes);
            error_count++;
        end

        // frame count at random points over two frames
        frames_max = 0;
        while (cycle + 9000 < CHECK_CLKS) begin
            repeat ($urandom % 8000) @(posedge clk_core_12288);
            read_and_check(pattern_pkg::REG_FRAME_COUNT, rdata, ack_cycle);
            bus_release();
            if (int'(rdata) > frames_max) frames_max = int'(rdata);
        end
        if (frames_max < 2) begin
            $display("ERROR: frame count never reached 2 during the run");
            error_count++;
        end

        // let the monitor finish both frames
        waited = 0;
        while (cycle <= CHECK_CLKS && waited < 20000) begin
            @(posedge clk_core_12288);
            waited++;
        end
        if (cycle <= CHECK_CLKS) begin
            $display("ERROR: raster check did not reach the end of the second frame");
            timeout_count++;
        end
        if (sclk_rises < 2) begin
            $display("ERROR: audio_sclk toggled too rarely to measure a period");
            error_count++;
        end
        if (lrck_rises < 2) begin
            $display("ERROR: audio_lrck toggled too rarely to measure a period");
            error_count++;
        end

        $display("errors %0d, timeouts %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: video_output.sv
////////////////////////////////////////////////////////////
// video output stage
// registered sync pulses, data enable and grey fill
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_output (
    input  logic                           clk_core_12288,
    input  logic                           reset_n,
    input  logic [pattern_pkg::COORD_W-1:0] x_count,
    input  logic [pattern_pkg::COORD_W-1:0] y_count,
    input  logic                           frame_start,
    output logic [pattern_pkg::PIXEL_W-1:0] video_rgb,
    output logic                           video_de,
    output logic                           video_vs,
    output logic                           video_hs
);

    // active window bounds, end values exclusive
    localparam int X_FIRST = pattern_pkg::H_BPORCH;
    localparam int X_END   = pattern_pkg::H_BPORCH + pattern_pkg::H_ACTIVE;
    localparam int Y_FIRST = pattern_pkg::V_BPORCH;
    localparam int Y_END   = pattern_pkg::V_BPORCH + pattern_pkg::V_ACTIVE;

    // same level on r, g and b
    localparam logic [pattern_pkg::PIXEL_W-1:0] FILL_RGB = {
        pattern_pkg::FILL_LEVEL,
        pattern_pkg::FILL_LEVEL,
        pattern_pkg::FILL_LEVEL
    };

    localparam logic [pattern_pkg::COORD_W-1:0] HS_POS =
        pattern_pkg::COORD_W'(pattern_pkg::HS_X);

    logic x_active;
    logic y_active;
    logic active;

    ////////////////////////////////////////////////////////////
    // window decode

    assign x_active = (x_count >= X_FIRST) && (x_count < X_END);
    assign y_active = (y_count >= Y_FIRST) && (y_count < Y_END);
    assign active   = x_active && y_active;

    ////////////////////////////////////////////////////////////
    // output registers

    // everything lags the raster position by one clock
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            // new frame, single cycle
            video_vs  <= frame_start;
            // new line, in the back porch
            video_hs  <= (x_count == HS_POS);
            video_de  <= active;
            // black outside the window
            video_rgb <= active ? FILL_RGB : '0;
        end
    end

endmodule

// File: video_timing.sv
////////////////////////////////////////////////////////////
// raster timing generator
// free running x/y counters over the full 400 x 512 raster
// and the shared frame start event
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_timing (
    input  logic                           clk_core_12288,
    input  logic                           reset_n,
    output logic [pattern_pkg::COORD_W-1:0] x_count,
    output logic [pattern_pkg::COORD_W-1:0] y_count,
    output logic                           frame_start
);

    // last position of a line and of a frame
    localparam logic [pattern_pkg::COORD_W-1:0] X_LAST =
        pattern_pkg::COORD_W'(pattern_pkg::H_TOTAL - 1);
    localparam logic [pattern_pkg::COORD_W-1:0] Y_LAST =
        pattern_pkg::COORD_W'(pattern_pkg::V_TOTAL - 1);

    // line wrap strobe
    logic x_wrap;

    assign x_wrap = (x_count == X_LAST);

    ////////////////////////////////////////////////////////////
    // horizontal counter

    // one step per clock, back to 0 after the last clock of a line
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
        end else if (x_wrap) begin
            x_count <= '0;
        end else begin
            x_count <= x_count + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // vertical counter

    // steps only when the line wraps
    always_ff @(posedge clk_core_12288 or negedge reset_n) begin
        if (!reset_n) begin
            y_count <= '0;
        end else if (x_wrap) begin
            if (y_count == Y_LAST) begin
                y_count <= '0;
            end else begin
                y_count <= y_count + 1'b1;
            end
        end
    end

    // top left corner of the raster
    // shared by the sync logic and the frame counter
    assign frame_start = (x_count == '0) && (y_count == '0);

endmodule

// File: vlog.f
pattern_pkg.sv
video_timing.sv
video_output.sv
status_counters.sv
i2s_silence.sv
reg_bus.sv
core_top.sv
tb_core_top.sv
